/* flist.f */
src/i3c_mon_pkg.sv
src/edge_filter.sv
src/stable_level_detector.sv
src/bus_event_ctrl.sv
src/mon_wb_regs.sv
src/i3c_bus_monitor_top.sv
test/tb_bus_monitor_properties.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_top -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"

/* test/tb_top.sv */
// Testbench for the I3C/I2C bus monitor. Drives SCL/SDA and the Wishbone port,
// runs random bus conditions and compares counters and status with a model.
`timescale 1ns/1ns

module tb_top;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic scl, sda;
  logic cyc, stb, we, ack, irq;
  logic mon_en, busy_m;
  i3c_mon_pkg::reg_addr_t adr;
  i3c_mon_pkg::wb_data_t  dat_w, dat_r, rd;
  logic [2:0]  sticky_m;  // {stop, rstart, start}
  logic [31:0] cnt_m [3];
  int errors = 0;
  int test_errs = 0;
  int tests_failed = 0;
  int tests_run = 0;
  int hold = 20;  // Cycles per bus step

  i3c_bus_monitor_top #(.CNT_W(16)) dut0 (
    .clk_i, .rst_ni, .scl_i(scl), .sda_i(sda), .wb_cyc_i(cyc), .wb_stb_i(stb),
    .wb_we_i(we), .wb_adr_i(adr), .wb_dat_i(dat_w), .wb_dat_o(dat_r),
    .wb_ack_o(ack), .irq_o(irq)
  );

  initial forever #20 clk_i = ~clk_i;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // One classic cycle, held until ack
  task automatic wb_access(input logic w, input i3c_mon_pkg::reg_addr_t a,
                           input logic [31:0] d);
    bit done;
    done = 1'b0;
    @(posedge clk_i);
    #2;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = a;
    dat_w = d;
    for (int n = 0; n < 20 && !done; n++) begin
      @(posedge clk_i);
      #2;
      if (ack) done = 1'b1;
    end
    rd  = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    if (!done) begin
      $display("Wishbone access to address %0d got no ack in time", a);
      errors++;
    end
  endtask

  task automatic set_timing(input logic [19:0] r, input logic [19:0] f, input logic [19:0] h);
    wb_access(1'b1, i3c_mon_pkg::REG_T_R, {12'd0, r});
    wb_access(1'b1, i3c_mon_pkg::REG_T_F, {12'd0, f});
    wb_access(1'b1, i3c_mon_pkg::REG_T_HD, {12'd0, h});
    hold = int'(r) + int'(f) + int'(h) + 10;
  endtask

  task automatic drive_step(input logic s, input logic d, input int n);
    @(posedge clk_i);
    #2;
    scl = s;
    sda = d;
    repeat (n - 1) @(posedge clk_i);
  endtask

  task automatic drive_lines(input logic s, input logic d);
    drive_step(s, d, hold);
  endtask

  // Model of the condition rules
  task automatic model_start();
    if (!mon_en) return;
    if (busy_m) begin
      cnt_m[1]++;
      sticky_m[1] = 1'b1;
    end else begin
      cnt_m[0]++;
      sticky_m[0] = 1'b1;
    end
    busy_m = 1'b1;
  endtask

  task automatic model_stop();
    if (!mon_en) return;
    cnt_m[2]++;
    sticky_m[2] = 1'b1;
    busy_m = 1'b0;
  endtask

  task automatic bus_start();
    drive_lines(1'b0, sda);
    drive_lines(1'b0, 1'b1);
    drive_lines(1'b1, 1'b1);
    drive_lines(1'b1, 1'b0);
    drive_lines(1'b0, 1'b0);
    model_start();
  endtask

  task automatic bus_stop();
    drive_lines(1'b0, sda);
    drive_lines(1'b0, 1'b0);
    drive_lines(1'b1, 1'b0);
    drive_lines(1'b1, 1'b1);
    model_stop();
  endtask

  task automatic data_toggle();  // SDA moves only while SCL is low
    logic d;
    d = ~sda;
    drive_lines(1'b0, sda);
    drive_lines(1'b0, d);
    drive_lines(1'b1, d);
    drive_lines(1'b0, d);
  endtask

  task automatic check_counts();
    wb_access(1'b0, i3c_mon_pkg::REG_CNT_START, '0);
    check("cnt_start", rd, cnt_m[0]);
    wb_access(1'b0, i3c_mon_pkg::REG_CNT_RSTART, '0);
    check("cnt_rstart", rd, cnt_m[1]);
    wb_access(1'b0, i3c_mon_pkg::REG_CNT_STOP, '0);
    check("cnt_stop", rd, cnt_m[2]);
    wb_access(1'b0, i3c_mon_pkg::REG_STATUS, '0);
    check("status", rd, {28'd0, busy_m, sticky_m});
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errs) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      $display("Test %0d %s: FAIL", tests_run, name);
      tests_failed++;
    end
    test_errs = errors;
  endtask

  initial begin
    #(40 * 200000);
    $display("Simulation timed out before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] v;
    void'($urandom(32'ha364eb47));
    rst_ni   = 1'b0;
    scl      = 1'b1;
    sda      = 1'b1;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat_w    = '0;
    mon_en   = 1'b0;
    busy_m   = 1'b0;
    sticky_m = '0;
    cnt_m    = '{default: '0};
    repeat (8) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    check("irq_o", {31'd0, irq}, 32'd0);
    check_counts();
    v = $urandom % 4;
    wb_access(1'b1, i3c_mon_pkg::REG_CTRL, v);
    wb_access(1'b0, i3c_mon_pkg::REG_CTRL, '0);
    check("ctrl", rd, v);
    for (int i = 1; i < 4; i++) begin
      v = $urandom & 32'h000f_ffff;
      wb_access(1'b1, i3c_mon_pkg::reg_addr_t'(i), v);
      wb_access(1'b0, i3c_mon_pkg::reg_addr_t'(i), '0);
      check("timing reg", rd, v);
    end
    wb_access(1'b1, i3c_mon_pkg::REG_CTRL, 32'd0);
    end_test("register access");

    set_timing(20'd3, 20'd3, 20'd3);
    bus_start();
    bus_stop();
    check_counts();
    end_test("disabled monitor");

    set_timing(20'($urandom % 8 + 1), 20'($urandom % 8 + 1), 20'($urandom % 8 + 1));
    wb_access(1'b1, i3c_mon_pkg::REG_CTRL, 32'd1);
    mon_en = 1'b1;
    for (int i = 0; i < 30; i++) begin
      v = $urandom % 4;
      if (v < 2) bus_start();
      else if (v == 2) bus_stop();
      else data_toggle();
    end
    check_counts();
    end_test("event classification");

    set_timing(20'd3, 20'd6, 20'd6);
    bus_stop();
    drive_step(1'b1, 1'b0, 5);  // Shorter than t_f; the return high is a STOP
    drive_lines(1'b1, 1'b1);
    model_stop();
    drive_step(1'b1, 1'b0, 8);  // SCL falls before the hold time ends
    drive_lines(1'b0, 1'b0);
    drive_lines(1'b0, 1'b1);
    drive_lines(1'b1, 1'b1);
    check_counts();
    end_test("glitch rejection");

    wb_access(1'b1, i3c_mon_pkg::REG_CTRL, 32'd3);
    wb_access(1'b1, i3c_mon_pkg::REG_STATUS, 32'd7);
    sticky_m = '0;
    bus_start();
    bus_start();
    bus_stop();
    check_counts();
    check("irq_o", {31'd0, irq}, 32'd1);
    for (int i = 0; i < 3; i++) begin
      wb_access(1'b1, i3c_mon_pkg::REG_STATUS, 32'd1 << i);
      sticky_m[i] = 1'b0;
      wb_access(1'b0, i3c_mon_pkg::REG_STATUS, '0);
      check("status", rd, {28'd0, busy_m, sticky_m});
      check("irq_o", {31'd0, irq}, {31'd0, |sticky_m});
    end
    end_test("sticky status and interrupt");

    if (dut0.u_ctrl.u_props.fail_cnt != 0) begin
      $display("Concurrent assertions failed %0d times", dut0.u_ctrl.u_props.fail_cnt);
      errors += dut0.u_ctrl.u_props.fail_cnt;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) $display("ALL TESTS PASSED");
    else $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* test/tb_bus_monitor_properties.sv */
// Concurrent checks on the bus event control module.
// Bound to every bus_event_ctrl instance from this file.
`timescale 1ns/1ns

module bus_event_ctrl_properties (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    enable_i,
  input i3c_mon_pkg::bus_event_t events_o,
  input i3c_mon_pkg::bus_state_e state_q
);

  int   fail_cnt = 0;  // Number of failed assertions
  logic start_seen_q;  // A START was reported and no STOP since

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_seen_q <= 1'b0;
    end else if (!enable_i || events_o.stop) begin
      start_seen_q <= 1'b0;
    end else if (events_o.start) begin
      start_seen_q <= 1'b1;
    end
  end

  // Conditions are mutually exclusive
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(events_o))
    else begin
      $error("More than one bus event in the same cycle");
      fail_cnt++;
    end

  // A repeated START needs an earlier START with no STOP since
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   events_o.rstart |-> start_seen_q &&
                   (state_q == i3c_mon_pkg::BUS_BUSY))
    else begin
      $error("Repeated START reported while the bus is idle");
      fail_cnt++;
    end

  // Disabling also drops any pending detection
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (!enable_i || !$past(enable_i)) |-> events_o == '0)
    else begin
      $error("Bus event reported while the monitor is disabled");
      fail_cnt++;
    end

endmodule

bind bus_event_ctrl bus_event_ctrl_properties u_props (
  .clk_i, .rst_ni, .enable_i, .events_o, .state_q
);

/* src/i3c_bus_monitor_top.sv */
// Top level of the passive I3C/I2C bus monitor.
// SCL and SDA must arrive already synchronized to clk_i; software controls
// the monitor over the Wishbone port and gets irq_o on new events.
`timescale 1ns/1ns

module i3c_bus_monitor_top #(
  parameter int CNT_W = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   scl_i,
  input  logic                   sda_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  i3c_mon_pkg::reg_addr_t wb_adr_i,
  input  i3c_mon_pkg::wb_data_t  wb_dat_i,
  output i3c_mon_pkg::wb_data_t  wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   irq_o
);

  i3c_mon_pkg::timing_cfg_t cfg;
  i3c_mon_pkg::bus_event_t  events;
  logic enable;
  logic busy;
  logic sda_fall, sda_rise;
  logic scl_fall, scl_rise;
  logic scl_high;

  mon_wb_regs #(.CNT_W(CNT_W)) u_regs (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .events_i(events), .busy_i(busy),
    .enable_o(enable), .cfg_o(cfg), .irq_o
  );

  // Falling edges use the fall time, rising edges the rise time
  edge_filter #(.DETECT_FALL(1'b1)) u_sda_fall (
    .clk_i, .rst_ni, .line_i(sda_i), .delay_i(cfg.t_f), .edge_o(sda_fall)
  );
  edge_filter #(.DETECT_FALL(1'b0)) u_sda_rise (
    .clk_i, .rst_ni, .line_i(sda_i), .delay_i(cfg.t_r), .edge_o(sda_rise)
  );
  edge_filter #(.DETECT_FALL(1'b1)) u_scl_fall (
    .clk_i, .rst_ni, .line_i(scl_i), .delay_i(cfg.t_f), .edge_o(scl_fall)
  );
  edge_filter #(.DETECT_FALL(1'b0)) u_scl_rise (
    .clk_i, .rst_ni, .line_i(scl_i), .delay_i(cfg.t_r), .edge_o(scl_rise)
  );

  stable_level_detector u_scl_high (
    .clk_i, .rst_ni, .line_i(scl_i), .delay_i(cfg.t_r), .stable_o(scl_high)
  );

  bus_event_ctrl u_ctrl (
    .clk_i, .rst_ni, .enable_i(enable), .scl_i, .cfg_i(cfg),
    .sda_fall_i(sda_fall), .sda_rise_i(sda_rise),
    .scl_fall_i(scl_fall), .scl_rise_i(scl_rise), .scl_high_i(scl_high),
    .events_o(events), .busy_o(busy)
  );

endmodule

/* src/mon_wb_regs.sv */
// Wishbone classic register slave of the bus monitor.
// Holds control and timing values, sticky W1C event status, wrapping event
// counters and the registered interrupt line.
`timescale 1ns/1ns

module mon_wb_regs #(
  parameter int CNT_W = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  i3c_mon_pkg::reg_addr_t   wb_adr_i,
  input  i3c_mon_pkg::wb_data_t    wb_dat_i,
  output i3c_mon_pkg::wb_data_t    wb_dat_o,
  output logic                     wb_ack_o,
  input  i3c_mon_pkg::bus_event_t  events_i,
  input  logic                     busy_i,
  output logic                     enable_o,
  output i3c_mon_pkg::timing_cfg_t cfg_o,
  output logic                     irq_o
);

  logic                  ack_q;
  logic                  req;
  logic                  wr;
  logic                  irq_en_q;
  logic [2:0]            status_q;  // {stop, rstart, start}
  logic [2:0]            status_set;
  logic [CNT_W-1:0]      cnt_start_q;
  logic [CNT_W-1:0]      cnt_rstart_q;
  logic [CNT_W-1:0]      cnt_stop_q;
  i3c_mon_pkg::wb_data_t rdata;

  assign req = wb_cyc_i & wb_stb_i & ~ack_q;  // One ack per request
  assign wr  = req & wb_we_i;

  assign status_set = {events_i.stop, events_i.rstart, events_i.start};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      enable_o <= 1'b0;
      irq_en_q <= 1'b0;
      cfg_o    <= '0;
      status_q <= '0;
      irq_o    <= 1'b0;
    end else begin
      ack_q <= req;
      if (wr && (wb_adr_i == i3c_mon_pkg::REG_CTRL)) begin
        enable_o <= wb_dat_i[0];
        irq_en_q <= wb_dat_i[1];
      end
      if (wr && (wb_adr_i == i3c_mon_pkg::REG_T_R)) cfg_o.t_r <= wb_dat_i[19:0];
      if (wr && (wb_adr_i == i3c_mon_pkg::REG_T_F)) cfg_o.t_f <= wb_dat_i[19:0];
      if (wr && (wb_adr_i == i3c_mon_pkg::REG_T_HD)) cfg_o.t_hd_dat <= wb_dat_i[19:0];
      // A new event wins over a clear in the same cycle
      if (wr && (wb_adr_i == i3c_mon_pkg::REG_STATUS)) begin
        status_q <= (status_q & ~wb_dat_i[2:0]) | status_set;
      end else begin
        status_q <= status_q | status_set;
      end
      irq_o <= irq_en_q & (|status_q);
    end
  end

  // Event counters wrap
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_start_q  <= '0;
      cnt_rstart_q <= '0;
      cnt_stop_q   <= '0;
    end else begin
      if (events_i.start) cnt_start_q <= cnt_start_q + 1'b1;
      if (events_i.rstart) cnt_rstart_q <= cnt_rstart_q + 1'b1;
      if (events_i.stop) cnt_stop_q <= cnt_stop_q + 1'b1;
    end
  end

  always_comb begin
    case (wb_adr_i)
      i3c_mon_pkg::REG_CTRL:       rdata = {30'd0, irq_en_q, enable_o};
      i3c_mon_pkg::REG_T_R:        rdata = {12'd0, cfg_o.t_r};
      i3c_mon_pkg::REG_T_F:        rdata = {12'd0, cfg_o.t_f};
      i3c_mon_pkg::REG_T_HD:       rdata = {12'd0, cfg_o.t_hd_dat};
      i3c_mon_pkg::REG_STATUS:     rdata = {28'd0, busy_i, status_q};
      i3c_mon_pkg::REG_CNT_START:  rdata = i3c_mon_pkg::wb_data_t'(cnt_start_q);
      i3c_mon_pkg::REG_CNT_RSTART: rdata = i3c_mon_pkg::wb_data_t'(cnt_rstart_q);
      default:                     rdata = i3c_mon_pkg::wb_data_t'(cnt_stop_q);
    endcase
  end

  // Read data, valid while ack is high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_dat_o <= '0;
    end else if (req) begin
      wb_dat_o <= rdata;
    end
  end

  assign wb_ack_o = ack_q;

endmodule

/* src/bus_event_ctrl.sv */
// Turns filtered SCL/SDA edges into START, REPEATED START and STOP pulses.
// A trigger must survive the data hold time with SCL high before it is
// reported; bus state decides between a first and a repeated START.
`timescale 1ns/1ns

module bus_event_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     enable_i,
  input  logic                     scl_i,
  input  i3c_mon_pkg::timing_cfg_t cfg_i,
  input  logic                     sda_fall_i,
  input  logic                     sda_rise_i,
  input  logic                     scl_fall_i,
  input  logic                     scl_rise_i,
  input  logic                     scl_high_i,
  output i3c_mon_pkg::bus_event_t  events_o,
  output logic                     busy_o
);

  i3c_mon_pkg::bus_state_e state_q;
  i3c_mon_pkg::timing_t    hold_cnt_q;  // Shared by START and STOP

  logic scl_edge;
  logic start_trig;
  logic stop_trig;
  logic start_pending_q;
  logic stop_pending_q;
  logic hold_done;
  logic start_det;
  logic stop_det;

  // SDA changes together with SCL are data, not a condition
  assign scl_edge   = scl_fall_i | scl_rise_i;
  assign start_trig = enable_i & scl_high_i & sda_fall_i & ~scl_edge;
  assign stop_trig  = enable_i & scl_high_i & sda_rise_i & ~scl_edge;

  assign hold_done = (hold_cnt_q >= cfg_i.t_hd_dat);

  assign start_det = enable_i & start_pending_q & scl_i & hold_done & ~stop_trig;
  assign stop_det  = enable_i & stop_pending_q & scl_i & hold_done & ~start_trig;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= '0;
    end else if (start_trig || stop_trig) begin
      hold_cnt_q <= i3c_mon_pkg::timing_t'(1);
    end else if (start_pending_q || stop_pending_q) begin
      hold_cnt_q <= hold_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pending_q <= 1'b0;
    end else if (start_trig) begin
      start_pending_q <= 1'b1;
    end else if (!enable_i || !scl_i || start_det || stop_trig) begin
      start_pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stop_pending_q <= 1'b0;
    end else if (stop_trig) begin
      stop_pending_q <= 1'b1;
    end else if (!enable_i || !scl_i || stop_det || start_trig) begin
      stop_pending_q <= 1'b0;
    end
  end

  // Bus ownership between START and STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_mon_pkg::BUS_IDLE;
    end else if (!enable_i || stop_det) begin
      state_q <= i3c_mon_pkg::BUS_IDLE;
    end else if (start_det) begin
      state_q <= i3c_mon_pkg::BUS_BUSY;
    end
  end

  assign events_o.start  = start_det && (state_q == i3c_mon_pkg::BUS_IDLE);
  assign events_o.rstart = start_det && (state_q == i3c_mon_pkg::BUS_BUSY);
  assign events_o.stop   = stop_det;

  assign busy_o = (state_q == i3c_mon_pkg::BUS_BUSY);

endmodule

/* src/stable_level_detector.sv */
// Flags that a bus line has stayed high for at least delay_i cycles.
// The flag drops in the same cycle the line goes low.
`timescale 1ns/1ns

module stable_level_detector (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 line_i,
  input  i3c_mon_pkg::timing_t delay_i,
  output logic                 stable_o
);

  i3c_mon_pkg::timing_t high_cnt_q;  // Consecutive high cycles so far

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      high_cnt_q <= '0;
    end else if (!line_i) begin
      high_cnt_q <= '0;
    end else if (high_cnt_q != '1) begin
      high_cnt_q <= high_cnt_q + 1'b1;  // Saturates at all ones
    end
  end

  assign stable_o = line_i && (high_cnt_q >= delay_i);

endmodule

/* src/edge_filter.sv */
// Confirms one edge polarity on a synchronized bus line.
// The edge pulse fires once the line has held its new level for delay_i
// cycles; a return to the old level in between cancels the edge.
`timescale 1ns/1ns

module edge_filter #(
  parameter bit DETECT_FALL = 1'b0  // 1 selects falling edges
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 line_i,
  input  i3c_mon_pkg::timing_t delay_i,
  output logic                 edge_o
);

  localparam logic NEW_LEVEL = !DETECT_FALL;

  logic                 line_q;
  logic                 at_level;
  logic                 raw_edge;
  i3c_mon_pkg::timing_t cnt_q;

  assign at_level = (line_i == NEW_LEVEL);
  assign raw_edge = at_level && (line_q != NEW_LEVEL);

  // Previous sample, lines idle high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_q <= 1'b1;
    end else begin
      line_q <= line_i;
    end
  end

  // Down counter armed by a raw edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (raw_edge) begin
      cnt_q <= delay_i;
    end else if (cnt_q != '0) begin
      if (at_level) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= '0;  // Glitch back to the old level
      end
    end
  end

  // A zero delay confirms on the raw edge itself
  assign edge_o = (raw_edge && (delay_i == '0)) ||
                  ((cnt_q == i3c_mon_pkg::timing_t'(1)) && at_level);

endmodule

/* src/i3c_mon_pkg.sv */
// Shared types and constants for the I3C/I2C bus monitor.
// Every design file refers to these through scoped names.
package i3c_mon_pkg;

  localparam int TIMING_W = 20;  // Width of every timing value

  typedef logic [TIMING_W-1:0] timing_t;  // Count of clock cycles
  typedef logic [31:0]         wb_data_t;
  typedef logic [2:0]          reg_addr_t;  // Word address

  // Timing configuration programmed by software
  typedef struct packed {
    timing_t t_r;
    timing_t t_f;
    timing_t t_hd_dat;
  } timing_cfg_t;

  // One-cycle pulses for each detected bus condition
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_event_t;

  localparam reg_addr_t REG_CTRL       = 3'd0;  // Bit 0 enable, bit 1 irq enable
  localparam reg_addr_t REG_T_R        = 3'd1;
  localparam reg_addr_t REG_T_F        = 3'd2;
  localparam reg_addr_t REG_T_HD       = 3'd3;
  localparam reg_addr_t REG_STATUS     = 3'd4;  // W1C event bits, bit 3 busy
  localparam reg_addr_t REG_CNT_START  = 3'd5;
  localparam reg_addr_t REG_CNT_RSTART = 3'd6;
  localparam reg_addr_t REG_CNT_STOP   = 3'd7;

  typedef enum logic {
    BUS_IDLE,
    BUS_BUSY
  } bus_state_e;

endpackage
